// ==== hw/l1dPkg.sv ====
// Shared constants and types for the L1 data cache.
// Holds the TileLink-UL opcodes, the word size and the controller state encoding.
// Referenced by scoped name from the RTL and the bus model.

`default_nettype none

package l1dPkg;

    // ************************************************************************
    // word geometry
    // ************************************************************************
    localparam int wordBits = 32;                       // data and address width

    // ************************************************************************
    // TileLink-UL channel encodings
    // ************************************************************************
    localparam logic [2:0] opPut           = 3'd0;      // A: PutFullData
    localparam logic [2:0] opGet           = 3'd4;      // A: Get
    localparam logic [2:0] opAccessAck     = 3'd0;      // D: ack for a put
    localparam logic [2:0] opAccessAckData = 3'd1;      // D: ack with read data

    localparam logic [3:0] sizeWord = 4'd2;             // 2^2 bytes, one word

    // ************************************************************************
    // controller FSM
    // ************************************************************************
    typedef enum logic [1:0] {
        stIdle       = 2'b00,                           // waiting or doing a lookup
        stWriteBus   = 2'b01,                           // write-back of a dirty victim
        stReadBus    = 2'b10,                           // fill from the bus
        stWriteCache = 2'b11                            // one cycle to install the fill
    } ctrlState;

endpackage

`default_nettype wire

// ==== hw/l1dCacheArray.sv ====
// Direct-mapped storage of the data cache, one word per line.
// Per-line valid, dirty, tag and data; the read port is registered,
// so a line appears one cycle after its index. One write port.

`default_nettype none

module l1dCacheArray #(
    parameter int indexBits = 4
) (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire  [indexBits-1:0]                     rdIndex,
    input  wire                                      wrEn,
    input  wire  [indexBits-1:0]                     wrIndex,
    input  wire  [l1dPkg::wordBits-indexBits-3:0]    wrTag,
    input  wire  [l1dPkg::wordBits-1:0]              wrData,
    input  wire                                      wrDirty,
    output logic [l1dPkg::wordBits-indexBits-3:0]    rdTag,
    output logic                                     rdValid,
    output logic                                     rdDirty,
    output logic [l1dPkg::wordBits-1:0]              rdData
);

    localparam int lines   = 1 << indexBits;
    localparam int tagBits = l1dPkg::wordBits - indexBits - 2;   // above index and byte offset

    logic [lines-1:0]                  validQ;          // line holds a word
    logic [lines-1:0]                  dirtyQ;          // word differs from memory
    logic [tagBits-1:0]                tagMem  [lines];
    logic [l1dPkg::wordBits-1:0]       dataMem [lines];

    // status bits, cleared by reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            validQ <= '0;
            dirtyQ <= '0;
            rdValid <= 1'b0;
            rdDirty <= 1'b0;
        end
        else
        begin
            rdValid <= validQ[rdIndex];                 // old value on a same-edge write
            rdDirty <= dirtyQ[rdIndex];
            if (wrEn)
            begin
                validQ[wrIndex] <= 1'b1;                // any write installs the line
                dirtyQ[wrIndex] <= wrDirty;
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge clk)
    begin
        rdTag  <= tagMem[rdIndex];
        rdData <= dataMem[rdIndex];
        if (wrEn)
        begin
            tagMem[wrIndex]  <= wrTag;
            dataMem[wrIndex] <= wrData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/l1dControl.sv ====
// Cache controller FSM.
// Latches a core request, compares the stored tag one cycle later and
// either answers a hit or walks write-back, fill and install on a miss.
// The bus port turns the state into A/D channel traffic.

`default_nettype none

module l1dControl #(
    parameter int indexBits = 4
) (
    input  wire                                      clk,
    input  wire                                      rst_n,
    // core side
    input  wire                                      reqValid,
    input  wire                                      reqWrite,
    input  wire  [l1dPkg::wordBits-1:0]              reqAddr,
    input  wire  [l1dPkg::wordBits-1:0]              reqWdata,
    output logic                                     respValid,
    output logic [l1dPkg::wordBits-1:0]              respRdata,
    output logic                                     respError,
    output logic                                     busy,
    // array side
    output logic [indexBits-1:0]                     rdIndex,
    output logic                                     wrEn,
    output logic [indexBits-1:0]                     wrIndex,
    output logic [l1dPkg::wordBits-indexBits-3:0]    wrTag,
    output logic [l1dPkg::wordBits-1:0]              wrData,
    output logic                                     wrDirty,
    input  wire  [l1dPkg::wordBits-indexBits-3:0]    rdTag,
    input  wire                                      rdValid,
    input  wire                                      rdDirty,
    input  wire  [l1dPkg::wordBits-1:0]              rdData,
    // bus port side
    output l1dPkg::ctrlState                         state,
    output logic [l1dPkg::wordBits-1:0]              evictAddr,
    output logic [l1dPkg::wordBits-1:0]              evictData,
    input  wire                                      putDone,
    input  wire                                      getDone,
    input  wire                                      busFault,
    input  wire  [l1dPkg::wordBits-1:0]              fillData
);

    localparam int tagBits = l1dPkg::wordBits - indexBits - 2;

    logic                              lookupQ;         // array read in flight
    logic                              reqWriteQ;
    logic [l1dPkg::wordBits-1:0]       reqAddrQ;
    logic [l1dPkg::wordBits-1:0]       reqWdataQ;
    logic [indexBits-1:0]              reqIndex;
    logic [tagBits-1:0]                reqTag;
    logic                              accept;
    logic                              hit;

    assign reqIndex = reqAddrQ[indexBits+1:2];
    assign reqTag   = reqAddrQ[l1dPkg::wordBits-1:indexBits+2];

    // busy covers lookup, the whole miss and the response cycle
    assign busy   = lookupQ || (state != l1dPkg::stIdle) || respValid;
    assign accept = reqValid && !busy;
    assign hit    = rdValid && (rdTag == reqTag);

    assign rdIndex = busy ? reqIndex : reqAddr[indexBits+1:2];   // keep reading the held line

    // victim address while writing back, request word address while filling
    assign evictAddr = (state == l1dPkg::stWriteBus) ? {rdTag, reqIndex, 2'b00}
                                                     : {reqAddrQ[l1dPkg::wordBits-1:2], 2'b00};
    assign evictData = rdData;                          // line is not written during WriteBus

    // ************************************************************************
    // array write
    // ************************************************************************
    always_comb
    begin
        wrEn    = 1'b0;
        wrIndex = reqIndex;
        wrTag   = reqTag;
        wrData  = reqWdataQ;
        wrDirty = 1'b1;
        if (lookupQ && hit && reqWriteQ)
        begin
            wrEn = 1'b1;                                // write hit, mark dirty
        end
        else if (state == l1dPkg::stWriteCache)
        begin
            wrEn    = 1'b1;
            wrData  = reqWriteQ ? reqWdataQ : fillData; // write miss overwrites the fill
            wrDirty = reqWriteQ;
        end
    end

    // ************************************************************************
    // FSM and response strobe
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= l1dPkg::stIdle;
            lookupQ   <= 1'b0;
            respValid <= 1'b0;
            respError <= 1'b0;
        end
        else
        begin
            lookupQ   <= accept;
            respValid <= 1'b0;                          // one-cycle pulse
            case (state)
                l1dPkg::stIdle:
                begin
                    if (lookupQ && hit)
                    begin
                        respValid <= 1'b1;
                        respError <= 1'b0;
                    end
                    else if (lookupQ && rdValid && rdDirty)
                        state <= l1dPkg::stWriteBus;    // evict first
                    else if (lookupQ)
                        state <= l1dPkg::stReadBus;     // clean or empty line
                end
                l1dPkg::stWriteBus:
                begin
                    if (putDone && busFault)
                    begin
                        respValid <= 1'b1;
                        respError <= 1'b1;
                        state     <= l1dPkg::stIdle;
                    end
                    else if (putDone)
                        state <= l1dPkg::stReadBus;
                end
                l1dPkg::stReadBus:
                begin
                    if (getDone && busFault)
                    begin
                        respValid <= 1'b1;              // line is left unfilled
                        respError <= 1'b1;
                        state     <= l1dPkg::stIdle;
                    end
                    else if (getDone)
                        state <= l1dPkg::stWriteCache;
                end
                default:
                begin
                    respValid <= 1'b1;                  // install done
                    respError <= 1'b0;
                    state     <= l1dPkg::stIdle;
                end
            endcase
        end
    end

    // request and read data registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            reqWriteQ <= reqWrite;
            reqAddrQ  <= reqAddr;
            reqWdataQ <= reqWdata;
        end
        if (lookupQ && hit)
            respRdata <= reqWriteQ ? reqWdataQ : rdData;
        else if (state == l1dPkg::stWriteCache)
            respRdata <= wrData;
    end

endmodule

`default_nettype wire

// ==== hw/l1dBusPort.sv ====
// TileLink-UL A/D channel port of the data cache.
// Builds Put or Get beats from the controller state and accepts D beats,
// turning matching acks into done pulses with a fault level.

`default_nettype none

module l1dBusPort #(
    parameter logic [4:0] sourceId = 5'd1
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  var   l1dPkg::ctrlState               state,
    input  wire  [l1dPkg::wordBits-1:0]          evictAddr,
    input  wire  [l1dPkg::wordBits-1:0]          evictData,
    // A channel
    output logic                                 aValid,
    input  wire                                  aReady,
    output logic [l1dPkg::wordBits-1:0]          aAddress,
    output logic [2:0]                           aOpcode,
    output logic [3:0]                           aSize,
    output logic [3:0]                           aMask,
    output logic [l1dPkg::wordBits-1:0]          aData,
    output logic [2:0]                           aParam,
    output logic [4:0]                           aSource,
    output logic                                 aCorrupt,
    // D channel
    input  wire                                  dValid,
    output logic                                 dReady,
    input  wire  [2:0]                           dOpcode,
    input  wire  [l1dPkg::wordBits-1:0]          dData,
    input  wire  [1:0]                           dParam,    // reserved, always zero on UL
    input  wire  [1:0]                           dSink,     // slave id, not checked
    input  wire  [4:0]                           dSource,
    input  wire                                  dDenied,
    input  wire                                  dCorrupt,
    input  wire  [3:0]                           dSize,
    // controller side
    output logic                                 putDone,
    output logic                                 getDone,
    output logic                                 busFault,
    output logic [l1dPkg::wordBits-1:0]          fillData
);

    logic sent;                                         // A beat taken, waiting for D
    logic inBus;                                        // controller wants the bus
    logic beat;                                         // D handshake this cycle
    logic idOk;                                         // source and size match

    assign inBus = (state == l1dPkg::stWriteBus) || (state == l1dPkg::stReadBus);

    // ************************************************************************
    // A channel, fields follow the state and hold until the handshake
    // ************************************************************************
    assign aValid   = inBus && !sent;
    assign aAddress = evictAddr;
    assign aOpcode  = (state == l1dPkg::stWriteBus) ? l1dPkg::opPut : l1dPkg::opGet;
    assign aSize    = l1dPkg::sizeWord;
    assign aMask    = 4'hf;                             // full word only
    assign aData    = evictData;
    assign aParam   = 3'd0;
    assign aSource  = sourceId;
    assign aCorrupt = 1'b0;                             // no ECC

    // ************************************************************************
    // D channel, unmatched beats are taken and dropped
    // ************************************************************************
    assign dReady   = inBus && sent;
    assign beat     = dValid && dReady;
    assign idOk     = (dSource == sourceId) && (dSize == l1dPkg::sizeWord);
    assign putDone  = beat && idOk && (state == l1dPkg::stWriteBus)
                      && (dOpcode == l1dPkg::opAccessAck);
    assign getDone  = beat && idOk && (state == l1dPkg::stReadBus)
                      && (dOpcode == l1dPkg::opAccessAckData);
    assign busFault = (putDone || getDone) && (dDenied || dCorrupt);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sent <= 1'b0;
        else if (!inBus || putDone || getDone)
            sent <= 1'b0;                               // next bus state asks afresh
        else if (aValid && aReady)
            sent <= 1'b1;
    end

    // fill word held for the install cycle
    always_ff @(posedge clk)
    begin
        if (getDone)
            fillData <= dData;
    end

endmodule

`default_nettype wire

// ==== hw/l1dTop.sv ====
// Top level of the write-back L1 data cache.
// Core side uses request/response strobes, bus side is TileLink-UL A and D.
// Only connects the array, the controller and the bus port.

`default_nettype none

module l1dTop #(
    parameter int         indexBits = 4,
    parameter logic [4:0] sourceId  = 5'd1
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // core side
    input  wire                                  reqValid,
    input  wire                                  reqWrite,
    input  wire  [l1dPkg::wordBits-1:0]          reqAddr,
    input  wire  [l1dPkg::wordBits-1:0]          reqWdata,
    output logic                                 respValid,
    output logic [l1dPkg::wordBits-1:0]          respRdata,
    output logic                                 respError,
    output logic                                 busy,
    // A channel
    output logic                                 aValid,
    input  wire                                  aReady,
    output logic [l1dPkg::wordBits-1:0]          aAddress,
    output logic [2:0]                           aOpcode,
    output logic [3:0]                           aSize,
    output logic [3:0]                           aMask,
    output logic [l1dPkg::wordBits-1:0]          aData,
    output logic [2:0]                           aParam,
    output logic [4:0]                           aSource,
    output logic                                 aCorrupt,
    // D channel
    input  wire                                  dValid,
    output logic                                 dReady,
    input  wire  [2:0]                           dOpcode,
    input  wire  [l1dPkg::wordBits-1:0]          dData,
    input  wire  [1:0]                           dParam,
    input  wire  [4:0]                           dSource,
    input  wire  [1:0]                           dSink,
    input  wire                                  dDenied,
    input  wire                                  dCorrupt,
    input  wire  [3:0]                           dSize
);

    // controller to array
    logic [indexBits-1:0]                        rdIndex;
    logic                                        wrEn;
    logic [indexBits-1:0]                        wrIndex;
    logic [l1dPkg::wordBits-indexBits-3:0]       wrTag;
    logic [l1dPkg::wordBits-1:0]                 wrData;
    logic                                        wrDirty;
    logic [l1dPkg::wordBits-indexBits-3:0]       rdTag;
    logic                                        rdValid;
    logic                                        rdDirty;
    logic [l1dPkg::wordBits-1:0]                 rdData;
    // controller to bus port
    l1dPkg::ctrlState                            state;
    logic [l1dPkg::wordBits-1:0]                 evictAddr;
    logic [l1dPkg::wordBits-1:0]                 evictData;
    logic                                        putDone;
    logic                                        getDone;
    logic                                        busFault;
    logic [l1dPkg::wordBits-1:0]                 fillData;

    l1dCacheArray #(.indexBits(indexBits)) cacheArray (.*);

    l1dControl #(.indexBits(indexBits)) control (.*);

    l1dBusPort #(.sourceId(sourceId)) busPort (.*);

endmodule

`default_nettype wire

// ==== verif/l1dBusModel.sv ====
// Behavioral TileLink-UL slave for the cache testbench.
// Serves one A beat at a time from a sparse word memory, with random aReady
// and response waits, an A beat counter and one-shot error injection.

`default_nettype none

module l1dBusModel (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [3:0]                       maxDelay,        // bound of each random wait
    input  wire                              injectCorrupt,   // flag the next response corrupt
    input  wire                              injectDenied,    // flag the next response denied
    input  wire                              aValid,
    output logic                             aReady,
    input  wire  [l1dPkg::wordBits-1:0]      aAddress,
    input  wire  [2:0]                       aOpcode,
    input  wire  [l1dPkg::wordBits-1:0]      aData,
    input  wire  [4:0]                       aSource,
    output logic                             dValid,
    input  wire                              dReady,
    output logic [2:0]                       dOpcode,
    output logic [l1dPkg::wordBits-1:0]      dData,
    output logic [1:0]                       dParam,
    output logic [4:0]                       dSource,
    output logic [1:0]                       dSink,
    output logic                             dDenied,
    output logic                             dCorrupt,
    output logic [3:0]                       dSize
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [l1dPkg::wordBits-1:0] mem [logic [l1dPkg::wordBits-1:0]];   // words stored by Put
    int                          aBeats;               // A handshakes seen
    logic [2:0]                  lastOp;               // newest A beat
    logic [l1dPkg::wordBits-1:0] lastAddr;
    logic [2:0]                  prevOp;               // the beat before it
    logic [l1dPkg::wordBits-1:0] prevAddr;

    // untouched words follow a pattern over every address bit
    function automatic logic [l1dPkg::wordBits-1:0] peek(input logic [l1dPkg::wordBits-1:0] addr);
        if (mem.exists(addr))
            return mem[addr];
        return {addr[15:0], ~addr[31:16]} ^ 32'h6b3d_91c5;
    endfunction

    function automatic int waitCycles();
        return int'($urandom % ({28'd0, maxDelay} + 32'd1));
    endfunction

    // ************************************************************************
    // one transaction: A handshake, then one D beat
    // ************************************************************************
    task automatic serveBeat();
        logic [2:0]                  op;
        logic [l1dPkg::wordBits-1:0] addr;
        logic [4:0]                  src;
        repeat (waitCycles()) @(posedge clk);
        aReady <= 1'b1;
        @(posedge clk);                                 // aValid held, beat moves here
        aReady <= 1'b0;
        op       = aOpcode;
        addr     = aAddress;
        src      = aSource;
        aBeats++;
        prevOp   = lastOp;
        prevAddr = lastAddr;
        lastOp   = op;
        lastAddr = addr;
        if (op == l1dPkg::opPut)
            mem[addr] = aData;
        repeat (waitCycles()) @(posedge clk);
        dValid   <= 1'b1;
        dOpcode  <= (op == l1dPkg::opPut) ? l1dPkg::opAccessAck : l1dPkg::opAccessAckData;
        dData    <= peek(addr);
        dSource  <= src;                                // echo the master id
        dSize    <= l1dPkg::sizeWord;
        dCorrupt <= injectCorrupt;
        dDenied  <= injectDenied;
        do
            @(posedge clk);
        while (!dReady);                                // hold until the cache takes it
        dValid   <= 1'b0;
        dCorrupt <= 1'b0;
        dDenied  <= 1'b0;
    endtask

    initial
    begin
        aReady   = 1'b0;
        dValid   = 1'b0;
        dOpcode  = 3'd0;
        dData    = '0;
        dParam   = 2'd0;                                // reserved on UL
        dSource  = 5'd0;
        dSink    = 2'd0;
        dDenied  = 1'b0;
        dCorrupt = 1'b0;
        dSize    = 4'd0;
        aBeats   = 0;
        forever
        begin
            @(posedge clk);
            if (rst_n && aValid)
                serveBeat();
        end
    end

endmodule

`default_nettype wire

// ==== verif/l1dTopTb.sv ====
// Testbench top of the L1 data cache.
// Runs directed tests against the cache and a behavioral TileLink-UL slave,
// checking responses, hit latency, bus traffic and slave memory.

`default_nettype none

module l1dTopTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 16;
    localparam int mixedOps    = 30;
    localparam int worstDelay  = 5;                     // slave wait bound in the mixed test
    localparam int worstReq    = 2 * (2 * worstDelay + 6) + 4;   // put and get, both waits
    localparam int watchdogNs  = (resetCycles + (mixedOps + 12) * worstReq + 100) * clkPeriod;
    localparam logic [31:0] addrA = 32'h0000_0104;      // index 1
    localparam logic [31:0] addrX = 32'h0000_0248;      // index 2
    localparam logic [31:0] addrY = 32'h0000_0648;      // index 2, other tag
    localparam logic [31:0] addrZ = 32'h0000_3010;      // index 4
    localparam logic [31:0] addrW = 32'h0000_3050;      // index 4, other tag

    logic        clk = 1'b0;
    logic        rst_n;
    logic        reqValid;
    logic        reqWrite;
    logic [31:0] reqAddr;
    logic [31:0] reqWdata;
    logic        respValid;
    logic [31:0] respRdata;
    logic        respError;
    logic        busy;
    logic        aValid;
    logic        aReady;
    logic [31:0] aAddress;
    logic [2:0]  aOpcode;
    logic [3:0]  aSize;
    logic [3:0]  aMask;
    logic [31:0] aData;
    logic [2:0]  aParam;
    logic [4:0]  aSource;
    logic        aCorrupt;
    logic        dValid;
    logic        dReady;
    logic [2:0]  dOpcode;
    logic [31:0] dData;
    logic [1:0]  dParam;
    logic [4:0]  dSource;
    logic [1:0]  dSink;
    logic        dDenied;
    logic        dCorrupt;
    logic [3:0]  dSize;
    logic [3:0]  maxDelay;
    logic        injectCorrupt;
    logic        injectDenied;
    int          reqCount;                              // requests issued
    int          respCount;                             // respValid pulses seen
    logic [31:0] refMem [logic [31:0]];                 // expected memory for the mixed test

    l1dTop #(.indexBits(4), .sourceId(5'd1)) UUT (.*);
    l1dBusModel busModel (.*);

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk)
        if (respValid)
            respCount <= respCount + 1;

    // every A beat is a full-word access from master 1
    always @(posedge clk)
    begin
        if (aValid && aReady)
        begin
            compare("aSize", 32'(aSize), 32'd2);
            compare("aMask", 32'(aMask), 32'hf);
            compare("aParam", 32'(aParam), 32'd0);
            compare("aSource", 32'(aSource), 32'd1);
            compare("aCorrupt", 32'(aCorrupt), 32'd0);
        end
    end

    // ends a run that stops making progress
    initial
    begin
        #(watchdogNs);
        $display("timeout: no finish after %0d ns", watchdogNs);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic idleOutputs();
        compare("aValid", 32'(aValid), 32'd0);
        compare("dReady", 32'(dReady), 32'd0);
        compare("respValid", 32'(respValid), 32'd0);
        compare("busy", 32'(busy), 32'd0);
    endtask

    // one core access; cycles counts edges from the request edge to respValid
    task automatic doRequest(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err, output int cycles);
        @(posedge clk);
        while (busy)
            @(posedge clk);
        reqValid <= 1'b1;
        reqWrite <= write;
        reqAddr  <= addr;
        reqWdata <= wdata;
        reqCount++;
        @(posedge clk);                                 // request edge
        reqValid <= 1'b0;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!respValid);
        rdata = respRdata;
        err   = respError;
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic resetValues();
        repeat (resetCycles / 2) @(posedge clk);
        idleOutputs();                                  // mid reset
        repeat (resetCycles - resetCycles / 2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        idleOutputs();                                  // just out of reset
    endtask

    task automatic readMissThenHit();
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        int          beats;
        beats = busModel.aBeats;
        doRequest(1'b0, addrA, '0, rdata, err, cycles);
        compare("respRdata", rdata, busModel.peek(addrA));
        compare("respError", 32'(err), 32'd0);
        compare("aBeats", busModel.aBeats, beats + 1);
        compare("aOpcode", 32'(busModel.lastOp), 32'(l1dPkg::opGet));
        doRequest(1'b0, addrA, '0, rdata, err, cycles);
        compare("respRdata", rdata, busModel.peek(addrA));
        compare("hit latency", cycles, 2);
        compare("aBeats", busModel.aBeats, beats + 1);  // hit stays off the bus
    endtask

    task automatic writeHitRead();
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        int          beats;
        logic [31:0] memBefore;
        beats     = busModel.aBeats;
        memBefore = busModel.peek(addrA);
        doRequest(1'b1, addrA, 32'ha5c3_0104, rdata, err, cycles);
        compare("write hit latency", cycles, 2);
        doRequest(1'b0, addrA, '0, rdata, err, cycles);
        compare("respRdata", rdata, 32'ha5c3_0104);
        compare("read hit latency", cycles, 2);
        compare("aBeats", busModel.aBeats, beats);
        compare("slave word", busModel.peek(addrA), memBefore);   // line only dirty
    endtask

    task automatic dirtyEviction();
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        int          beats;
        doRequest(1'b1, addrX, 32'h7e11_0248, rdata, err, cycles);   // write miss, line dirty
        beats = busModel.aBeats;
        doRequest(1'b0, addrY, '0, rdata, err, cycles);
        compare("aBeats", busModel.aBeats, beats + 2);
        compare("first aOpcode", 32'(busModel.prevOp), 32'(l1dPkg::opPut));
        compare("first aAddress", busModel.prevAddr, addrX);
        compare("second aOpcode", 32'(busModel.lastOp), 32'(l1dPkg::opGet));
        compare("second aAddress", busModel.lastAddr, addrY);
        compare("slave word", busModel.peek(addrX), 32'h7e11_0248);
        compare("respRdata", rdata, busModel.peek(addrY));
    endtask

    task automatic backPressureMix();
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        maxDelay <= 4'(worstDelay);
        for (int i = 0; i < mixedOps; i++)
        begin
            addr  = 32'h0000_2000 + (($urandom % 4) << 6) + (($urandom % 2) << 2);
            write = 1'($urandom % 2);
            wdata = $urandom;
            doRequest(write, addr, wdata, rdata, err, cycles);
            compare("respError", 32'(err), 32'd0);
            if (write)
                refMem[addr] = wdata;
            else if (refMem.exists(addr))
                compare("respRdata", rdata, refMem[addr]);
            else
                compare("respRdata", rdata, busModel.peek(addr));   // never written
        end
        @(posedge clk);
        compare("respValid count", respCount, reqCount);
        maxDelay <= 4'd2;
    endtask

    task automatic faultRecovery();
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        int          beats;
        beats = busModel.aBeats;
        injectCorrupt <= 1'b1;
        doRequest(1'b0, addrZ, '0, rdata, err, cycles);
        injectCorrupt <= 1'b0;
        compare("respError", 32'(err), 32'd1);
        doRequest(1'b0, addrZ, '0, rdata, err, cycles);  // line was left invalid
        compare("respError", 32'(err), 32'd0);
        compare("respRdata", rdata, busModel.peek(addrZ));
        compare("aBeats", busModel.aBeats, beats + 2);
        injectDenied <= 1'b1;
        doRequest(1'b0, addrW, '0, rdata, err, cycles);  // clean miss on the same line
        injectDenied <= 1'b0;
        compare("respError", 32'(err), 32'd1);
        compare("aBeats", busModel.aBeats, beats + 3);
    endtask

    initial
    begin
        void'($urandom(32'hf79a));
        rst_n         = 1'b0;
        reqValid      = 1'b0;
        reqWrite      = 1'b0;
        reqAddr       = '0;
        reqWdata      = '0;
        maxDelay      = 4'd2;
        injectCorrupt = 1'b0;
        injectDenied  = 1'b0;
        reqCount      = 0;
        respCount     = 0;
        resetValues();
        readMissThenHit();
        writeHitRead();
        dirtyEviction();
        backPressureMix();
        faultRecovery();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== l1dTop.f ====
hw/l1dPkg.sv
hw/l1dCacheArray.sv
hw/l1dControl.sv
hw/l1dBusPort.sv
hw/l1dTop.sv
verif/l1dBusModel.sv
verif/l1dTopTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it and grade the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f l1dTop.f \
    --top-module l1dTopTb -o l1dTopTbSim
./obj_dir/l1dTopTbSim | tee sim.log

if grep -q "^NO ERRORS$" sim.log
then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
